//--- Bender.yml
package:
  name: cpu16

sources:
  - files:
      - source/cpu_pkg.sv
      - source/register_file.sv
      - source/address_unit.sv
      - source/instruction_decoder.sv
      - source/datapath.sv
      - source/cpu_controller.sv
      - source/cpu_top.sv
  - target: simulation
    files:
      - verification/tb_memory.sv
      - verification/tb_cpu.sv

//--- sim.f
source/cpu_pkg.sv
source/register_file.sv
source/address_unit.sv
source/instruction_decoder.sv
source/datapath.sv
source/cpu_controller.sv
source/cpu_top.sv
verification/tb_memory.sv
verification/tb_cpu.sv

//--- source/address_unit.sv
module address_unit #(
   parameter cpu_pkg::addr_t reset_pc_value = '0
) (
   input  logic           clk,
   input  logic           reset_pc,
   input  logic           load_pc,
   input  logic           load_addr,
   input  logic           addr_sel,
   input  cpu_pkg::word_t c_out,
   output cpu_pkg::addr_t pc,
   output cpu_pkg::addr_t mem_addr
);

   cpu_pkg::addr_t data_addr;

   always_ff @(posedge clk) begin
      if (load_pc)
         pc <= reset_pc ? reset_pc_value : pc + 9'd1;
   end

   // Word address of the next load or store
   always_ff @(posedge clk) begin
      if (load_addr)
         data_addr <= c_out[8:0];
   end

   assign mem_addr = addr_sel ? pc : data_addr;

endmodule

//--- source/cpu_controller.sv
module cpu_controller (
   input  logic             clk,
   input  logic             reset,
   input  cpu_pkg::opcode_t opcode,
   input  logic [1:0]       op,
   input  logic             mem_ack,
   output logic             loada,
   output logic             loadb,
   output logic             loadc,
   output logic             write,
   output logic             asel,
   output logic             bsel,
   output cpu_pkg::vsel_t   vsel,
   output cpu_pkg::nsel_t   nsel,
   output logic             load_ir,
   output logic             load_pc,
   output logic             reset_pc,
   output logic             load_addr,
   output logic             addr_sel,
   output logic             mem_req,
   output logic             mem_write,
   output logic             halted
);

   cpu_pkg::state_t state;
   cpu_pkg::state_t next_state;

   always_ff @(posedge clk) begin
      if (reset)
         state <= cpu_pkg::reset_st;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      case (state)
         cpu_pkg::reset_st:   next_state = cpu_pkg::fetch_req;
         cpu_pkg::fetch_req:  if (mem_ack) next_state = cpu_pkg::fetch_wait;
         cpu_pkg::fetch_wait: if (!mem_ack) next_state = cpu_pkg::update_pc;
         cpu_pkg::update_pc:  next_state = cpu_pkg::decode;
         cpu_pkg::decode: begin
            case (opcode)
               cpu_pkg::move_op:
                  next_state = op[1] ? cpu_pkg::write_imm : cpu_pkg::get_b;
               cpu_pkg::alu_op:
                  next_state = (op == cpu_pkg::alu_not) ? cpu_pkg::get_b : cpu_pkg::get_a;
               cpu_pkg::load_op, cpu_pkg::store_op:
                  next_state = cpu_pkg::get_a;
               // HALT and anything undefined stop the machine
               default:
                  next_state = cpu_pkg::halt_st;
            endcase
         end
         cpu_pkg::get_a:
            next_state = (opcode == cpu_pkg::alu_op) ? cpu_pkg::get_b : cpu_pkg::add_imm;
         cpu_pkg::get_b:      next_state = cpu_pkg::alu_exec;
         cpu_pkg::get_b_rd:   next_state = cpu_pkg::alu_exec;
         cpu_pkg::alu_exec:
            next_state = (opcode == cpu_pkg::store_op) ? cpu_pkg::store_req : cpu_pkg::write_reg;
         cpu_pkg::add_imm:    next_state = cpu_pkg::write_addr;
         cpu_pkg::write_addr:
            next_state = (opcode == cpu_pkg::load_op) ? cpu_pkg::load_req : cpu_pkg::get_b_rd;
         cpu_pkg::load_req:   if (mem_ack) next_state = cpu_pkg::load_wait;
         cpu_pkg::load_wait:  if (!mem_ack) next_state = cpu_pkg::fetch_req;
         cpu_pkg::store_req:  if (mem_ack) next_state = cpu_pkg::store_wait;
         cpu_pkg::store_wait: if (!mem_ack) next_state = cpu_pkg::fetch_req;
         cpu_pkg::write_reg:  next_state = cpu_pkg::fetch_req;
         cpu_pkg::write_imm:  next_state = cpu_pkg::fetch_req;
         default:             next_state = cpu_pkg::halt_st;
      endcase
   end

   always_comb begin
      loada     = 1'b0;
      loadb     = 1'b0;
      loadc     = 1'b0;
      write     = 1'b0;
      asel      = 1'b0;
      bsel      = 1'b0;
      vsel      = cpu_pkg::from_c;
      nsel      = cpu_pkg::sel_rm;
      load_ir   = 1'b0;
      load_pc   = 1'b0;
      reset_pc  = 1'b0;
      load_addr = 1'b0;
      addr_sel  = 1'b1;
      mem_req   = 1'b0;
      mem_write = 1'b0;
      halted    = 1'b0;
      case (state)
         cpu_pkg::reset_st: begin
            load_pc  = 1'b1;
            reset_pc = 1'b1;
         end
         cpu_pkg::fetch_req: begin
            mem_req = 1'b1;
            // Instruction is captured while read data is valid
            load_ir = mem_ack;
         end
         cpu_pkg::update_pc: load_pc = 1'b1;
         cpu_pkg::get_a: begin
            loada = 1'b1;
            nsel  = cpu_pkg::sel_rn;
         end
         cpu_pkg::get_b: loadb = 1'b1;
         cpu_pkg::get_b_rd: begin
            loadb = 1'b1;
            nsel  = cpu_pkg::sel_rd;
         end
         cpu_pkg::alu_exec: begin
            loadc = 1'b1;
            // MOV and STR pass B through with a zero A operand
            asel  = (opcode == cpu_pkg::move_op) || (opcode == cpu_pkg::store_op);
         end
         cpu_pkg::add_imm: begin
            loadc = 1'b1;
            bsel  = 1'b1;
         end
         cpu_pkg::write_addr: load_addr = 1'b1;
         cpu_pkg::load_req: begin
            addr_sel = 1'b0;
            mem_req  = 1'b1;
            nsel     = cpu_pkg::sel_rd;
            vsel     = cpu_pkg::from_mem;
            write    = mem_ack;
         end
         cpu_pkg::load_wait:  addr_sel = 1'b0;
         cpu_pkg::store_req: begin
            addr_sel  = 1'b0;
            mem_req   = 1'b1;
            mem_write = 1'b1;
         end
         cpu_pkg::store_wait: addr_sel = 1'b0;
         cpu_pkg::write_reg: begin
            write = 1'b1;
            nsel  = cpu_pkg::sel_rd;
         end
         cpu_pkg::write_imm: begin
            write = 1'b1;
            nsel  = cpu_pkg::sel_rn;
            vsel  = cpu_pkg::from_imm8;
         end
         cpu_pkg::halt_st: halted = 1'b1;
         default: ;
      endcase
   end

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

   localparam int word_width    = 16;
   localparam int addr_width    = 9;
   localparam int reg_num_width = 3;
   localparam int reg_count     = 8;

   typedef logic [word_width-1:0]    word_t;
   typedef logic [addr_width-1:0]    addr_t;
   typedef logic [reg_num_width-1:0] reg_num_t;

   // Opcode field in bits 15 to 13
   typedef enum logic [2:0] {
      alu_op   = 3'b101,
      move_op  = 3'b110,
      load_op  = 3'b011,
      store_op = 3'b100,
      halt_op  = 3'b111
   } opcode_t;

   typedef logic [1:0] alu_code_t;

   localparam alu_code_t alu_add = 2'b00;
   // Compare has no flags left to set, so it adds
   localparam alu_code_t alu_cmp = 2'b01;
   localparam alu_code_t alu_and = 2'b10;
   localparam alu_code_t alu_not = 2'b11;

   typedef logic [1:0] shift_t;

   localparam shift_t shift_none  = 2'b00;
   localparam shift_t shift_left  = 2'b01;
   localparam shift_t shift_right = 2'b10;
   localparam shift_t shift_arith = 2'b11;

   // Which register field addresses the register file
   typedef enum logic [1:0] {
      sel_rm,
      sel_rd,
      sel_rn
   } nsel_t;

   // Write-back source
   typedef enum logic [1:0] {
      from_c,
      from_pc,
      from_imm8,
      from_mem
   } vsel_t;

   typedef enum logic [4:0] {
      reset_st, fetch_req, fetch_wait, update_pc, decode,
      get_a, get_b, get_b_rd, alu_exec, add_imm,
      write_addr, load_req, load_wait, store_req, store_wait,
      write_reg, write_imm, halt_st
   } state_t;

endpackage

//--- source/cpu_top.sv
module cpu_top #(
   parameter cpu_pkg::addr_t reset_pc_value = '0
) (
   input  logic           clk,
   input  logic           reset,
   output logic           mem_req,
   output logic           mem_write,
   output cpu_pkg::addr_t mem_addr,
   output cpu_pkg::word_t mem_wdata,
   input  logic           mem_ack,
   input  cpu_pkg::word_t mem_rdata,
   output logic           halted
);

   logic loada;
   logic loadb;
   logic loadc;
   logic write;
   logic asel;
   logic bsel;
   logic load_ir;
   logic load_pc;
   logic reset_pc;
   logic load_addr;
   logic addr_sel;
   logic [1:0] op;

   cpu_pkg::vsel_t     vsel;
   cpu_pkg::nsel_t     nsel;
   cpu_pkg::opcode_t   opcode;
   cpu_pkg::reg_num_t  reg_num;
   cpu_pkg::shift_t    shift;
   cpu_pkg::alu_code_t alu_code;
   cpu_pkg::word_t     sximm5;
   cpu_pkg::word_t     sximm8;
   cpu_pkg::word_t     c_out;
   cpu_pkg::addr_t     pc;

   // Store data comes straight from the result register
   assign mem_wdata = c_out;

   cpu_controller controller0 (
      .clk(clk), .reset(reset), .opcode(opcode), .op(op), .mem_ack(mem_ack),
      .loada(loada), .loadb(loadb), .loadc(loadc), .write(write),
      .asel(asel), .bsel(bsel), .vsel(vsel), .nsel(nsel),
      .load_ir(load_ir), .load_pc(load_pc), .reset_pc(reset_pc),
      .load_addr(load_addr), .addr_sel(addr_sel),
      .mem_req(mem_req), .mem_write(mem_write), .halted(halted)
   );

   instruction_decoder decoder0 (
      .clk(clk), .load_ir(load_ir), .mem_rdata(mem_rdata), .nsel(nsel),
      .opcode(opcode), .op(op), .reg_num(reg_num), .shift(shift),
      .alu_code(alu_code), .sximm5(sximm5), .sximm8(sximm8)
   );

   datapath datapath0 (
      .clk(clk), .loada(loada), .loadb(loadb), .loadc(loadc), .write(write),
      .asel(asel), .bsel(bsel), .vsel(vsel), .reg_num(reg_num), .shift(shift),
      .alu_code(alu_code), .sximm5(sximm5), .sximm8(sximm8),
      .mem_rdata(mem_rdata), .pc(pc), .c_out(c_out)
   );

   address_unit #(.reset_pc_value(reset_pc_value)) address0 (
      .clk(clk), .reset_pc(reset_pc), .load_pc(load_pc), .load_addr(load_addr),
      .addr_sel(addr_sel), .c_out(c_out), .pc(pc), .mem_addr(mem_addr)
   );

endmodule

//--- source/datapath.sv
module datapath (
   input  logic               clk,
   input  logic               loada,
   input  logic               loadb,
   input  logic               loadc,
   input  logic               write,
   input  logic               asel,
   input  logic               bsel,
   input  cpu_pkg::vsel_t     vsel,
   input  cpu_pkg::reg_num_t  reg_num,
   input  cpu_pkg::shift_t    shift,
   input  cpu_pkg::alu_code_t alu_code,
   input  cpu_pkg::word_t     sximm5,
   input  cpu_pkg::word_t     sximm8,
   input  cpu_pkg::word_t     mem_rdata,
   input  cpu_pkg::addr_t     pc,
   output cpu_pkg::word_t     c_out
);

   cpu_pkg::word_t read_data;
   cpu_pkg::word_t write_data;
   cpu_pkg::word_t a_reg;
   cpu_pkg::word_t b_reg;
   cpu_pkg::word_t b_shift;
   cpu_pkg::word_t ain;
   cpu_pkg::word_t bin;
   cpu_pkg::word_t alu_out;

   register_file regs0 (
      .clk(clk), .write(write), .reg_num(reg_num),
      .write_data(write_data), .read_data(read_data)
   );

   always_ff @(posedge clk) begin
      if (loada)
         a_reg <= read_data;
      if (loadb)
         b_reg <= read_data;
      if (loadc)
         c_out <= alu_out;
   end

   always_comb begin
      case (shift)
         cpu_pkg::shift_left:  b_shift = {b_reg[14:0], 1'b0};
         cpu_pkg::shift_right: b_shift = {1'b0, b_reg[15:1]};
         cpu_pkg::shift_arith: b_shift = {b_reg[15], b_reg[15:1]};
         default:              b_shift = b_reg;
      endcase
   end

   assign ain = asel ? '0 : a_reg;
   assign bin = bsel ? sximm5 : b_shift;

   always_comb begin
      case (alu_code)
         cpu_pkg::alu_add, cpu_pkg::alu_cmp: alu_out = ain + bin;
         cpu_pkg::alu_and:                   alu_out = ain & bin;
         default:                            alu_out = ~bin;
      endcase
   end

   always_comb begin
      case (vsel)
         cpu_pkg::from_pc:   write_data = {7'b0, pc};
         cpu_pkg::from_imm8: write_data = sximm8;
         cpu_pkg::from_mem:  write_data = mem_rdata;
         default:            write_data = c_out;
      endcase
   end

endmodule

//--- source/instruction_decoder.sv
module instruction_decoder (
   input  logic               clk,
   input  logic               load_ir,
   input  cpu_pkg::word_t     mem_rdata,
   input  cpu_pkg::nsel_t     nsel,
   output cpu_pkg::opcode_t   opcode,
   output logic [1:0]         op,
   output cpu_pkg::reg_num_t  reg_num,
   output cpu_pkg::shift_t    shift,
   output cpu_pkg::alu_code_t alu_code,
   output cpu_pkg::word_t     sximm5,
   output cpu_pkg::word_t     sximm8
);

   cpu_pkg::word_t ir;
   logic           mem_instr;

   always_ff @(posedge clk) begin
      if (load_ir)
         ir <= mem_rdata;
   end

   assign opcode   = cpu_pkg::opcode_t'(ir[15:13]);
   assign op       = ir[12:11];
   assign alu_code = ir[12:11];

   // LDR and STR reuse bits 4:3 as part of the offset
   assign mem_instr = (opcode == cpu_pkg::load_op) || (opcode == cpu_pkg::store_op);
   assign shift     = mem_instr ? cpu_pkg::shift_none : ir[4:3];

   assign sximm5 = {{11{ir[4]}}, ir[4:0]};
   assign sximm8 = {{8{ir[7]}}, ir[7:0]};

   always_comb begin
      case (nsel)
         cpu_pkg::sel_rd: reg_num = ir[7:5];
         cpu_pkg::sel_rn: reg_num = ir[10:8];
         default:         reg_num = ir[2:0];
      endcase
   end

endmodule

//--- source/register_file.sv
module register_file (
   input  logic              clk,
   input  logic              write,
   input  cpu_pkg::reg_num_t reg_num,
   input  cpu_pkg::word_t    write_data,
   output cpu_pkg::word_t    read_data
);

   cpu_pkg::word_t regs [cpu_pkg::reg_count];

   always_ff @(posedge clk) begin
      if (write)
         regs[reg_num] <= write_data;
   end

   // Read and write share the selected register number
   assign read_data = regs[reg_num];

endmodule

//--- verification/tb_cpu.sv
module tb_cpu;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period      = 100;
   localparam int instr_count     = 40;
   localparam int program_count   = 6;
   localparam int mem_words       = 2**cpu_pkg::addr_width;
   localparam int watchdog_cycles = 60 * instr_count * program_count;

   logic           clk;
   logic           reset;
   logic           mem_req;
   logic           mem_write;
   logic           mem_ack;
   logic           halted;
   logic [1:0]     ack_delay;
   cpu_pkg::addr_t mem_addr;
   cpu_pkg::word_t mem_wdata;
   cpu_pkg::word_t mem_rdata;

   logic [31:0]    lfsr = 32'h8ab6;
   int             value_errors = 0;
   int             protocol_errors = 0;
   cpu_pkg::word_t model_mem [mem_words];
   // Expected fetches, loads and stores in the order the CPU makes them
   bit             exp_write [$];
   cpu_pkg::addr_t exp_addr [$];
   cpu_pkg::word_t exp_data [$];
   logic           prev_req = 1'b0;
   logic           prev_write;
   cpu_pkg::addr_t prev_addr;
   cpu_pkg::word_t prev_wdata;

   cpu_top #(.reset_pc_value(9'd0)) dut0 (
      .clk(clk), .reset(reset), .mem_req(mem_req), .mem_write(mem_write),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ack(mem_ack),
      .mem_rdata(mem_rdata), .halted(halted)
   );

   tb_memory mem0 (
      .clk(clk), .reset(reset), .mem_req(mem_req), .mem_write(mem_write),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .ack_delay(ack_delay),
      .mem_ack(mem_ack), .mem_rdata(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic logic [31:0] random_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic cpu_pkg::word_t shift_operand(cpu_pkg::word_t v, cpu_pkg::shift_t s);
      case (s)
         2'b01:   return {v[14:0], 1'b0};
         2'b10:   return {1'b0, v[15:1]};
         2'b11:   return {v[15], v[15:1]};
         default: return v;
      endcase
   endfunction

   task automatic check_word(string name, cpu_pkg::word_t actual, cpu_pkg::word_t expected);
      if (actual !== expected) begin
         value_errors++;
         $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic check_addr(string name, cpu_pkg::addr_t actual, cpu_pkg::addr_t expected);
      if (actual !== expected) begin
         value_errors++;
         $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
      end
   endtask

   task automatic report_protocol_error(string what);
      protocol_errors++;
      $display("Error at %0d ns: %s", $time, what);
   endtask

   task automatic expect_access(bit write, cpu_pkg::addr_t addr, cpu_pkg::word_t data);
      exp_write.push_back(write);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // Random image everywhere with the program written over it from address 0
   task automatic build_program();
      int                slot;
      logic [2:0]        kind;
      cpu_pkg::reg_num_t rn;
      cpu_pkg::reg_num_t rd;
      cpu_pkg::reg_num_t rm;
      for (int a = 0; a < mem_words; a++)
         model_mem[a] = 16'(random_bits(16));
      for (int r = 0; r < 8; r++)
         model_mem[r] = {cpu_pkg::move_op, 2'b10, 3'(r), 8'(random_bits(8))};
      slot = 8;
      while (slot < instr_count - 1) begin
         kind = 3'(random_bits(3));
         rn = 3'(random_bits(3));
         rd = 3'(random_bits(3));
         rm = 3'(random_bits(3));
         if (kind >= 3'd6 && slot + 3 < instr_count) begin
            // Base of 216 to 246 keeps base plus offset at 200 or above
            model_mem[slot] = {cpu_pkg::move_op, 2'b10, rn, 8'(108 + random_bits(4))};
            model_mem[slot + 1] = {cpu_pkg::move_op, 2'b00, 3'd0, rn, cpu_pkg::shift_left, rn};
            model_mem[slot + 2] = {(kind == 3'd6) ? cpu_pkg::load_op : cpu_pkg::store_op,
                                   2'b00, rn, rd, 5'(random_bits(5))};
            slot += 3;
         end else begin
            if (kind < 3'd2)
               model_mem[slot] = {cpu_pkg::move_op, 2'b00, rn, rd, 2'(random_bits(2)), rm};
            else if (kind < 3'd5)
               model_mem[slot] = {cpu_pkg::alu_op, 2'(random_bits(2)), rn, rd,
                                  2'(random_bits(2)), rm};
            else
               model_mem[slot] = {cpu_pkg::move_op, 2'b10, rn, 8'(random_bits(8))};
            slot += 1;
         end
      end
      model_mem[instr_count - 1] = {cpu_pkg::halt_op, 13'd0};
   endtask

   // ISA model that records every memory access the CPU must make
   task automatic run_model();
      cpu_pkg::word_t regs [8];
      cpu_pkg::word_t ir;
      cpu_pkg::word_t b_val;
      cpu_pkg::word_t sum;
      cpu_pkg::addr_t pc;
      cpu_pkg::addr_t ea;
      bit             running;
      exp_write.delete();
      exp_addr.delete();
      exp_data.delete();
      pc = '0;
      running = 1'b1;
      while (running) begin
         ir = model_mem[pc];
         expect_access(1'b0, pc, '0);
         pc = pc + 9'd1;
         b_val = shift_operand(regs[ir[2:0]], ir[4:3]);
         sum = regs[ir[10:8]] + {{11{ir[4]}}, ir[4:0]};
         ea = sum[8:0];
         case (ir[15:13])
            cpu_pkg::move_op: begin
               if (ir[12])
                  regs[ir[10:8]] = {{8{ir[7]}}, ir[7:0]};
               else
                  regs[ir[7:5]] = b_val;
            end
            cpu_pkg::alu_op: begin
               case (ir[12:11])
                  2'b10:   regs[ir[7:5]] = regs[ir[10:8]] & b_val;
                  2'b11:   regs[ir[7:5]] = ~b_val;
                  default: regs[ir[7:5]] = regs[ir[10:8]] + b_val;
               endcase
            end
            cpu_pkg::load_op: begin
               expect_access(1'b0, ea, '0);
               regs[ir[7:5]] = model_mem[ea];
            end
            cpu_pkg::store_op: begin
               expect_access(1'b1, ea, regs[ir[7:5]]);
               model_mem[ea] = regs[ir[7:5]];
            end
            default: running = 1'b0;
         endcase
      end
   endtask

   task automatic compare_final_state(int p);
      if (exp_addr.size() != 0)
         report_protocol_error($sformatf("program %0d halted with %0d memory accesses missing",
                                         p, exp_addr.size()));
      for (int a = 0; a < mem_words; a++)
         check_word($sformatf("mem[%0d]", a), mem0.mem[a], model_mem[a]);
   endtask

   task automatic check_request();
      bit             w;
      cpu_pkg::addr_t a;
      cpu_pkg::word_t d;
      if (exp_addr.size() == 0) begin
         report_protocol_error("memory request after the program should have halted");
      end else begin
         w = exp_write.pop_front();
         a = exp_addr.pop_front();
         d = exp_data.pop_front();
         if (mem_write !== w)
            report_protocol_error(w ? "read request where a store was expected"
                                    : "store request where a read was expected");
         check_addr("mem_addr", mem_addr, a);
         if (w)
            check_word("mem_wdata", mem_wdata, d);
      end
   endtask

   // Handshake monitor
   always @(negedge clk) begin
      if (!reset) begin
         if (mem_req && !prev_req) begin
            if (mem_ack)
               report_protocol_error("mem_req raised while mem_ack was still high");
            check_request();
         end else if (mem_req) begin
            if (mem_write !== prev_write)
               report_protocol_error("mem_write changed during a request");
            check_addr("mem_addr", mem_addr, prev_addr);
            check_word("mem_wdata", mem_wdata, prev_wdata);
         end
      end
      prev_req = reset ? 1'b0 : mem_req;
      prev_write = mem_write;
      prev_addr = mem_addr;
      prev_wdata = mem_wdata;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("Timeout: the CPU did not halt on every program in time");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      reset = 1'b1;
      ack_delay = 2'd0;
      for (int p = 0; p < program_count; p++) begin
         if (p > 0) begin
            @(negedge clk);
            reset <= 1'b1;
         end
         build_program();
         for (int a = 0; a < mem_words; a++)
            mem0.mem[a] = model_mem[a];
         run_model();
         repeat (4) @(negedge clk);
         reset <= 1'b0;
         while (!halted) begin
            @(negedge clk);
            ack_delay <= 2'(random_bits(2));
         end
         // Idle cycles catch any request after HALT
         repeat (4) @(negedge clk);
         compare_final_state(p);
      end
      $display("Errors: %0d wrong values, %0d protocol errors", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- verification/tb_memory.sv
module tb_memory (
   input  logic           clk,
   input  logic           reset,
   input  logic           mem_req,
   input  logic           mem_write,
   input  cpu_pkg::addr_t mem_addr,
   input  cpu_pkg::word_t mem_wdata,
   input  logic [1:0]     ack_delay,
   output logic           mem_ack,
   output cpu_pkg::word_t mem_rdata
);
   timeunit 1ns;
   timeprecision 100ps;

   cpu_pkg::word_t mem [2**cpu_pkg::addr_width];
   logic           busy;
   logic [1:0]     wait_left;

   initial begin
      mem_ack   = 1'b0;
      mem_rdata = '0;
      busy      = 1'b0;
      wait_left = '0;
   end

   // Responds on the falling edge so the CPU sees settled ack and data
   always @(negedge clk) begin
      if (reset) begin
         mem_ack <= 1'b0;
         busy = 1'b0;
      end else if (mem_ack) begin
         // Return to zero once the request drops
         if (!mem_req)
            mem_ack <= 1'b0;
      end else if (mem_req) begin
         if (!busy) begin
            busy = 1'b1;
            wait_left = ack_delay;
         end
         if (wait_left == 2'd0) begin
            if (mem_write)
               mem[mem_addr] = mem_wdata;
            else
               mem_rdata <= mem[mem_addr];
            mem_ack <= 1'b1;
            busy = 1'b0;
         end else begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

endmodule
